/* sources.f */
+incdir+source
source/soc_pkg.sv
source/bus_decoder.sv
source/misc_regs.sv
source/scratch_ram.sv
source/flash_select_seq.sv
source/soc_misc_top.sv
testbench/tb_clock.sv
testbench/tb_soc_misc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the SoC bus testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_soc_misc \
	-f sources.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_soc_misc)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "STATUS: PASS" <<< "$sim_out"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* testbench/tb_soc_misc.sv */
// Testbench for the SoC system bus top level
// drives the bus master side and board inputs, keeps a shadow model of the
// register banks and scratch memory, and checks readback, pins and timing

`timescale 1ns/1ps
`include "soc_consts.svh"

module tb_soc_misc import soc_pkg::*; ();

	localparam int DRIVE_DELAY    = 10;
	localparam int TIMEOUT_CYCLES = 16;

	logic       clk48m;
	logic       rst;
	logic       bus_valid;
	bus_addr_t  bus_addr;
	bus_data_t  bus_wdata;
	bus_strb_t  bus_wstrb;
	bus_data_t  bus_rdata;
	logic       bus_ready;
	logic       bus_error_irq;
	logic [7:0] btn;
	led_t       led;
	genio_t     genio_in;
	genio_t     genio_out;
	genio_t     genio_oe;
	pmod_t      pmod_in;
	pmod_t      pmod_out;
	pmod_t      pmod_oe;
	logic       irda_sd;
	logic       fsel_d;
	logic       fsel_c;
	logic       programn;
	logic       addr_unmapped;

	int mismatches;
	int timeouts;
	int prop_errors;

	// shadow model
	genio_t    genio_out_m;
	genio_t    genio_oe_m;
	pmod_t     pmod_out_m;
	pmod_t     pmod_oe_m;
	logic      irda_m;
	bus_data_t mem_m [0:`RAM_WORDS-1];

	tb_clock i_clock (
		.clk48m (clk48m),
		.rst    (rst)
	);

	soc_misc_top i_dut (
		.clk48m          (clk48m),
		.rst             (rst),
		.bus_valid_i     (bus_valid),
		.bus_addr_i      (bus_addr),
		.bus_wdata_i     (bus_wdata),
		.bus_wstrb_i     (bus_wstrb),
		.bus_rdata_o     (bus_rdata),
		.bus_ready_o     (bus_ready),
		.bus_error_irq_o (bus_error_irq),
		.btn_i           (btn),
		.led_o           (led),
		.genio_in_i      (genio_in),
		.genio_out_o     (genio_out),
		.genio_oe_o      (genio_oe),
		.pmod_in_i       (pmod_in),
		.pmod_out_o      (pmod_out),
		.pmod_oe_o       (pmod_oe),
		.irda_sd_o       (irda_sd),
		.fsel_d_o        (fsel_d),
		.fsel_c_o        (fsel_c),
		.programn_o      (programn)
	);

	assign addr_unmapped = (bus_addr[31:28] != `SOC_REGION_MISC) &&
		(bus_addr[31:28] != `SOC_REGION_RAM);

	// ------------------------------------------------------------------------
	// bus protocol checks
	// ------------------------------------------------------------------------
	a_irq_unmapped: assert property (
		@(posedge clk48m) disable iff (rst)
		bus_error_irq == (bus_valid && addr_unmapped)
	) else begin
		prop_errors++;
		$display("bus error interrupt disagrees with the addressed region at %0t", $time);
	end

	a_ready_valid: assert property (
		@(posedge clk48m) disable iff (rst)
		bus_ready |-> bus_valid
	) else begin
		prop_errors++;
		$display("bus ready raised without valid at %0t", $time);
	end

	function automatic bus_addr_t misc_addr(input misc_idx_t idx);
		return {`SOC_REGION_MISC, 21'h0, idx, 2'b00};
	endfunction

	function automatic bus_addr_t ram_addr(input logic [5:0] word);
		return {`SOC_REGION_RAM, 20'h0, word, 2'b00};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			mismatches++;
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// one access, ready sampled mid-cycle so the next rising edge completes it
	task automatic bus_access(input bus_addr_t addr, input bus_data_t wdata,
			input bus_strb_t wstrb, output bus_data_t rdata, output int waits);
		int cycles;
		cycles = 0;
		@(posedge clk48m);
		#DRIVE_DELAY;
		bus_valid = 1'b1;
		bus_addr  = addr;
		bus_wdata = wdata;
		bus_wstrb = wstrb;
		@(negedge clk48m);
		while (!bus_ready && cycles < TIMEOUT_CYCLES) begin
			cycles++;
			@(negedge clk48m);
		end
		if (!bus_ready) begin
			timeouts++;
			$display("no ready for bus access to %h within %0d cycles", addr, TIMEOUT_CYCLES);
		end
		rdata = bus_rdata;
		waits = cycles;
		@(posedge clk48m);
		#DRIVE_DELAY;
		bus_valid = 1'b0;
		bus_wstrb = '0;
	endtask

	task automatic bus_write(input bus_addr_t addr, input bus_data_t wdata,
			input bus_strb_t wstrb);
		bus_data_t rdata;
		int        waits;
		bus_access(addr, wdata, wstrb, rdata, waits);
	endtask

	task automatic read_check(input string name, input bus_addr_t addr,
			input bus_data_t expected);
		bus_data_t rdata;
		int        waits;
		bus_access(addr, '0, '0, rdata, waits);
		check_value(name, expected, rdata);
	endtask

	task automatic check_general_io();
		bus_data_t r;
		int        op;
		misc_idx_t idx;
		for (int i = 0; i < 24; i++) begin
			r = $urandom();
			op = $urandom() % 4;
			case (op)
				0: idx = `MISC_REG_GENIO_OUT;
				1: idx = `MISC_REG_GENIO_W2S;
				2: idx = `MISC_REG_GENIO_W2C;
				default: idx = `MISC_REG_GENIO_OE;
			endcase
			bus_write(misc_addr(idx), r, 4'hF);
			case (op)
				0: genio_out_m = r[29:0];
				1: genio_out_m = genio_out_m | r[29:0];
				2: genio_out_m = genio_out_m & ~r[29:0];
				default: genio_oe_m = r[29:0];
			endcase
			read_check("genio_out readback", misc_addr(`MISC_REG_GENIO_OUT), {2'b0, genio_out_m});
			read_check("genio_oe readback", misc_addr(`MISC_REG_GENIO_OE), {2'b0, genio_oe_m});
			check_value("genio_out pins", {2'b0, genio_out_m}, {2'b0, genio_out});
			check_value("genio_oe pins", {2'b0, genio_oe_m}, {2'b0, genio_oe});
		end
		for (int i = 0; i < 4; i++) begin
			r = $urandom();
			genio_in = r[29:0];
			read_check("genio_in readback", misc_addr(`MISC_REG_GENIO_IN), {2'b0, r[29:0]});
		end
	endtask

	task automatic check_extension_bank();
		bus_data_t r;
		int        op;
		misc_idx_t idx;
		check_value("irda_sd after reset", 32'h1, {31'b0, irda_sd});
		for (int i = 0; i < 20; i++) begin
			r = $urandom();
			op = $urandom() % 4;
			case (op)
				0: idx = `MISC_REG_GPEXT_OUT;
				1: idx = `MISC_REG_GPEXT_W2S;
				2: idx = `MISC_REG_GPEXT_W2C;
				default: idx = `MISC_REG_GPEXT_OE;
			endcase
			bus_write(misc_addr(idx), r, 4'hF);
			case (op)
				0: begin
					irda_m     = r[30];
					pmod_out_m = r[23:16];
				end
				1: begin
					irda_m     = irda_m | r[30];
					pmod_out_m = pmod_out_m | r[23:16];
				end
				2: begin
					irda_m     = irda_m & ~r[30];
					pmod_out_m = pmod_out_m & ~r[23:16];
				end
				default: pmod_oe_m = r[23:16];
			endcase
			read_check("gpext_out readback", misc_addr(`MISC_REG_GPEXT_OUT),
				{1'b0, irda_m, 6'h0, pmod_out_m, 16'h0});
			read_check("gpext_oe readback", misc_addr(`MISC_REG_GPEXT_OE),
				{8'h0, pmod_oe_m, 16'h0});
			check_value("pmod_out pins", {24'h0, pmod_out_m}, {24'h0, pmod_out});
			check_value("pmod_oe pins", {24'h0, pmod_oe_m}, {24'h0, pmod_oe});
			check_value("irda_sd pin", {31'b0, irda_m}, {31'b0, irda_sd});
		end
		r = $urandom();
		pmod_in = r[7:0];
		read_check("gpext_in readback", misc_addr(`MISC_REG_GPEXT_IN), {8'h0, r[7:0], 16'h0});
	endtask

	task automatic check_led_and_ids();
		bus_data_t r;
		r = $urandom();
		bus_write(misc_addr(`MISC_REG_LED), r, 4'hF);
		check_value("led pins", {16'h0, r[15:0]}, {16'h0, led});
		// strobe bit 0 clear leaves the latch alone
		bus_write(misc_addr(`MISC_REG_LED), ~r, 4'hE);
		read_check("led readback", misc_addr(`MISC_REG_LED), {16'h0, r[15:0]});
		r = $urandom();
		btn = r[7:0];
		read_check("button readback", misc_addr(`MISC_REG_BTN), {24'h0, ~r[7:0]});
		read_check("soc version", misc_addr(`MISC_REG_SOC_VER), `SOC_VERSION);
		read_check("unused index 7", misc_addr(5'd7), 32'h0);
		read_check("unused index 31", misc_addr(5'd31), 32'h0);
	endtask

	task automatic check_scratch_memory();
		bus_data_t  r;
		bus_data_t  s;
		bus_data_t  rdata;
		bus_strb_t  strb;
		logic [5:0] word;
		int         waits;
		for (int w = 0; w < `RAM_WORDS; w++) begin
			r = $urandom();
			bus_access(ram_addr(6'(w)), r, 4'hF, rdata, waits);
			mem_m[w] = r;
			check_value("ram write wait states", 32'd1, waits);
		end
		for (int i = 0; i < 48; i++) begin
			r = $urandom();
			s = $urandom();
			word = s[5:0];
			strb = (s[11:8] == 4'h0) ? 4'h1 : s[11:8];
			bus_access(ram_addr(word), r, strb, rdata, waits);
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) begin
					mem_m[word][8*b +: 8] = r[8*b +: 8];
				end
			end
		end
		for (int w = 0; w < `RAM_WORDS; w++) begin
			bus_access(ram_addr(6'(w)), '0, '0, rdata, waits);
			check_value("ram read data", mem_m[w], rdata);
			check_value("ram read wait states", 32'd1, waits);
		end
	endtask

	task automatic check_unmapped();
		bus_data_t r;
		bus_data_t rdata;
		logic [3:0] region;
		int        waits;
		for (int i = 0; i < 6; i++) begin
			r = $urandom();
			region = r[31:28];
			if (region == `SOC_REGION_MISC || region == `SOC_REGION_RAM) begin
				region = 4'hF;
			end
			bus_access({region, r[27:0]}, r, (i == 5) ? 4'hF : 4'h0, rdata, waits);
			check_value("unmapped read data", `SOC_BUS_ERROR_DATA, rdata);
			check_value("unmapped wait states", 32'd0, waits);
		end
	endtask

	// cycle k is the one after edge E+k, E being the FLASH_SEL write edge
	task automatic watch_flash_select(input string name, input logic reload);
		logic prog_expected;
		for (int k = 0; k <= 12; k++) begin
			@(negedge clk48m);
			prog_expected = reload ? (k <= 7) : 1'b1;
			check_value({name, " fsel_c"}, {31'b0, (k >= 3 && k <= 5)}, {31'b0, fsel_c});
			check_value({name, " programn"}, {31'b0, prog_expected}, {31'b0, programn});
		end
	endtask

	task automatic check_flash_select();
		bus_write(misc_addr(`MISC_REG_FLASH_SEL), 32'h0000_0001, 4'hF);
		check_value("fsel_d after write", 32'h1, {31'b0, fsel_d});
		watch_flash_select("no key", 1'b0);
		read_check("flash_sel readback", misc_addr(`MISC_REG_FLASH_SEL), 32'h1);
		bus_write(misc_addr(`MISC_REG_FLASH_SEL), {`FSEL_RELOAD_KEY, 8'h00}, 4'hF);
		check_value("fsel_d after keyed write", 32'h0, {31'b0, fsel_d});
		watch_flash_select("reload key", 1'b1);
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		int cycles;
		mismatches  = 0;
		timeouts    = 0;
		prop_errors = 0;
		bus_valid   = 1'b0;
		bus_addr    = '0;
		bus_wdata   = '0;
		bus_wstrb   = '0;
		btn         = '0;
		genio_in    = '0;
		pmod_in     = '0;
		genio_out_m = '0;
		genio_oe_m  = '0;
		pmod_out_m  = '0;
		pmod_oe_m   = '0;
		irda_m      = 1'b1;
		void'($urandom(32'h4fd48998));
		cycles = 0;
		@(posedge clk48m);
		while (rst && cycles < TIMEOUT_CYCLES) begin
			cycles++;
			@(posedge clk48m);
		end
		if (rst) begin
			timeouts++;
			$display("reset was never released");
		end
		check_extension_bank();
		check_general_io();
		check_led_and_ids();
		check_scratch_memory();
		check_unmapped();
		// reload is final, so it runs last
		check_flash_select();
		$display("summary: %0d mismatches, %0d timeouts, %0d protocol errors",
			mismatches, timeouts, prop_errors);
		if (mismatches == 0 && timeouts == 0 && prop_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* testbench/tb_clock.sv */
// Testbench clock and reset
// 100 ns clock, synchronous reset held for the first four cycles

`timescale 1ns/1ps

module tb_clock (
	output logic clk48m,
	output logic rst
);

	initial begin
		clk48m = 1'b0;
		forever #50 clk48m = ~clk48m;
	end

	// release lands just after an edge, like every other driven input
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk48m);
		#10;
		rst = 1'b0;
	end

endmodule

/* source/soc_misc_top.sv */
// SoC system bus top level
// region decoder, misc register block, scratch memory and flash select
// sequencer wired to the bus master and the board pins

`timescale 1ns/1ps

module soc_misc_top import soc_pkg::*; (
	input  logic       clk48m,
	input  logic       rst,

	// bus master side
	input  logic       bus_valid_i,
	input  bus_addr_t  bus_addr_i,
	input  bus_data_t  bus_wdata_i,
	input  bus_strb_t  bus_wstrb_i,
	output bus_data_t  bus_rdata_o,
	output logic       bus_ready_o,
	output logic       bus_error_irq_o,

	// board pins
	input  logic [7:0] btn_i,
	output led_t       led_o,
	input  genio_t     genio_in_i,
	output genio_t     genio_out_o,
	output genio_t     genio_oe_o,
	input  pmod_t      pmod_in_i,
	output pmod_t      pmod_out_o,
	output pmod_t      pmod_oe_o,
	output logic       irda_sd_o,
	output logic       fsel_d_o,
	output logic       fsel_c_o,
	output logic       programn_o
);

	logic      misc_sel;
	logic      ram_sel;
	bus_data_t misc_rdata;
	bus_data_t ram_rdata;
	logic      ram_ready;
	logic      fsel_strobe;
	logic      reload_req;

	bus_decoder i_decoder (
		.clk48m       (clk48m),
		.rst          (rst),
		.bus_valid_i  (bus_valid_i),
		.bus_addr_i   (bus_addr_i),
		.misc_rdata_i (misc_rdata),
		.ram_rdata_i  (ram_rdata),
		.ram_ready_i  (ram_ready),
		.misc_sel_o   (misc_sel),
		.ram_sel_o    (ram_sel),
		.bus_rdata_o  (bus_rdata_o),
		.bus_ready_o  (bus_ready_o),
		.bus_error_o  (bus_error_irq_o)
	);

	misc_regs i_misc_regs (
		.clk48m        (clk48m),
		.rst           (rst),
		.misc_sel_i    (misc_sel),
		.bus_idx_i     (bus_addr_i[6:2]),
		.bus_wdata_i   (bus_wdata_i),
		.bus_wstrb_i   (bus_wstrb_i),
		.btn_i         (btn_i),
		.genio_in_i    (genio_in_i),
		.pmod_in_i     (pmod_in_i),
		.misc_rdata_o  (misc_rdata),
		.led_o         (led_o),
		.genio_out_o   (genio_out_o),
		.genio_oe_o    (genio_oe_o),
		.pmod_out_o    (pmod_out_o),
		.pmod_oe_o     (pmod_oe_o),
		.irda_sd_o     (irda_sd_o),
		.fsel_d_o      (fsel_d_o),
		.fsel_strobe_o (fsel_strobe),
		.reload_req_o  (reload_req)
	);

	// word address within the scratch memory
	scratch_ram i_scratch_ram (
		.clk48m      (clk48m),
		.rst         (rst),
		.ram_sel_i   (ram_sel),
		.ram_addr_i  (bus_addr_i[7:2]),
		.ram_wdata_i (bus_wdata_i),
		.ram_wstrb_i (bus_wstrb_i),
		.ram_rdata_o (ram_rdata),
		.ram_ready_o (ram_ready)
	);

	flash_select_seq i_fsel_seq (
		.clk48m        (clk48m),
		.rst           (rst),
		.fsel_strobe_i (fsel_strobe),
		.reload_req_i  (reload_req),
		.fsel_c_o      (fsel_c_o),
		.programn_o    (programn_o)
	);

endmodule

/* source/flash_select_seq.sv */
// Flash select and reload sequencer
// delays the flash select clock edge after a FLASH_SEL write and pulls
// PROGRAMN once the select has settled and a reload was requested

`timescale 1ns/1ps
`include "soc_consts.svh"

module flash_select_seq import soc_pkg::*; (
	input  logic clk48m,
	input  logic rst,
	input  logic fsel_strobe_i,
	input  logic reload_req_i,
	output logic fsel_c_o,
	output logic programn_o
);

	fsel_state_t state_q;
	logic [2:0]  count_q;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			state_q <= FSEL_IDLE;
			count_q <= '0;
		end else begin
			case (state_q)
				FSEL_IDLE: begin
					if (fsel_strobe_i) begin
						count_q <= `FSEL_DELAY_START;
						state_q <= FSEL_COUNT;
					end
				end
				FSEL_COUNT: begin
					// a new write restarts the delay
					if (fsel_strobe_i) begin
						count_q <= `FSEL_DELAY_START;
					end else begin
						count_q <= count_q - 3'd1;
						if (count_q == 3'd1) begin
							state_q <= reload_req_i ? FSEL_RELOAD : FSEL_IDLE;
						end
					end
				end
				// reload is final, only reset leaves it
				FSEL_RELOAD: begin
				end
				default: begin
					state_q <= FSEL_IDLE;
				end
			endcase
		end
	end

	assign fsel_c_o   = (count_q <= `FSEL_CLK_HI) && (count_q >= `FSEL_CLK_LO);
	assign programn_o = (state_q != FSEL_RELOAD);

	// once the FPGA reload starts the pin must stay low
	a_programn_sticky: assert property (
		@(posedge clk48m) disable iff (rst)
		!programn_o |=> !programn_o
	) else $error("programn released before reset");

endmodule

/* source/scratch_ram.sv */
// Scratch word memory
// byte-strobed writes, registered read data, one wait state per access

`timescale 1ns/1ps
`include "soc_consts.svh"

module scratch_ram import soc_pkg::*; (
	input  logic      clk48m,
	input  logic      rst,
	input  logic      ram_sel_i,
	input  logic [5:0] ram_addr_i,
	input  bus_data_t ram_wdata_i,
	input  bus_strb_t ram_wstrb_i,
	output bus_data_t ram_rdata_o,
	output logic      ram_ready_o
);

	bus_data_t mem [0:`RAM_WORDS-1];
	logic      pending_q;

	// second cycle of the access completes it
	assign ram_ready_o = ram_sel_i && pending_q;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			pending_q <= 1'b0;
		end else if (ram_ready_o) begin
			pending_q <= 1'b0;
		end else if (ram_sel_i) begin
			pending_q <= 1'b1;
		end
	end

	// read is fetched in the wait cycle, write lands on the ready edge
	always_ff @(posedge clk48m) begin
		if (ram_sel_i && !pending_q) begin
			ram_rdata_o <= mem[ram_addr_i];
		end
		for (int b = 0; b < 4; b++) begin
			if (ram_ready_o && ram_wstrb_i[b]) begin
				mem[ram_addr_i][8*b +: 8] <= ram_wdata_i[8*b +: 8];
			end
		end
	end

endmodule

/* source/misc_regs.sv */
// Miscellaneous register block
// LED latch, button readback, version word, general IO and extension banks
// with set/clear writes, and the flash select control register

`timescale 1ns/1ps
`include "soc_consts.svh"

module misc_regs import soc_pkg::*; (
	input  logic      clk48m,
	input  logic      rst,
	input  logic      misc_sel_i,
	input  misc_idx_t bus_idx_i,
	input  bus_data_t bus_wdata_i,
	input  bus_strb_t bus_wstrb_i,
	input  logic [7:0] btn_i,
	input  genio_t    genio_in_i,
	input  pmod_t     pmod_in_i,
	output bus_data_t misc_rdata_o,
	output led_t      led_o,
	output genio_t    genio_out_o,
	output genio_t    genio_oe_o,
	output pmod_t     pmod_out_o,
	output pmod_t     pmod_oe_o,
	output logic      irda_sd_o,
	output logic      fsel_d_o,
	output logic      fsel_strobe_o,
	output logic      reload_req_o
);

	logic wr_en;

	// only the low strobe bit qualifies a register write
	assign wr_en = misc_sel_i && bus_wstrb_i[0];

	// ------------------------------------------------------------------------
	// register writes
	// ------------------------------------------------------------------------
	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_o         <= '0;
			genio_out_o   <= '0;
			genio_oe_o    <= '0;
			pmod_out_o    <= '0;
			pmod_oe_o     <= '0;
			irda_sd_o     <= 1'b1;
			fsel_d_o      <= 1'b0;
			fsel_strobe_o <= 1'b0;
			reload_req_o  <= 1'b0;
		end else begin
			fsel_strobe_o <= 1'b0;
			if (wr_en) begin
				case (bus_idx_i)
					`MISC_REG_LED: begin
						led_o <= bus_wdata_i[15:0];
					end
					`MISC_REG_FLASH_SEL: begin
						fsel_d_o      <= bus_wdata_i[0];
						fsel_strobe_o <= 1'b1;
						// the key arms an FPGA reload once the select has settled
						if (bus_wdata_i[31:8] == `FSEL_RELOAD_KEY) begin
							reload_req_o <= 1'b1;
						end
					end
					`MISC_REG_GENIO_OUT: begin
						genio_out_o <= bus_wdata_i[29:0];
					end
					`MISC_REG_GENIO_OE: begin
						genio_oe_o <= bus_wdata_i[29:0];
					end
					`MISC_REG_GENIO_W2S: begin
						genio_out_o <= genio_out_o | bus_wdata_i[29:0];
					end
					`MISC_REG_GENIO_W2C: begin
						genio_out_o <= genio_out_o & ~bus_wdata_i[29:0];
					end
					`MISC_REG_GPEXT_OUT: begin
						irda_sd_o  <= bus_wdata_i[30];
						pmod_out_o <= bus_wdata_i[23:16];
					end
					`MISC_REG_GPEXT_OE: begin
						pmod_oe_o <= bus_wdata_i[23:16];
					end
					`MISC_REG_GPEXT_W2S: begin
						irda_sd_o  <= irda_sd_o | bus_wdata_i[30];
						pmod_out_o <= pmod_out_o | bus_wdata_i[23:16];
					end
					`MISC_REG_GPEXT_W2C: begin
						irda_sd_o  <= irda_sd_o & ~bus_wdata_i[30];
						pmod_out_o <= pmod_out_o & ~bus_wdata_i[23:16];
					end
					default: begin
					end
				endcase
			end
		end
	end

	// ------------------------------------------------------------------------
	// readback
	// ------------------------------------------------------------------------
	always_comb begin
		case (bus_idx_i)
			`MISC_REG_LED:       misc_rdata_o = {16'h0, led_o};
			// buttons are active low on the board
			`MISC_REG_BTN:       misc_rdata_o = {24'h0, ~btn_i};
			`MISC_REG_SOC_VER:   misc_rdata_o = `SOC_VERSION;
			`MISC_REG_FLASH_SEL: misc_rdata_o = {31'h0, fsel_d_o};
			`MISC_REG_GENIO_IN:  misc_rdata_o = {2'h0, genio_in_i};
			`MISC_REG_GENIO_OUT: misc_rdata_o = {2'h0, genio_out_o};
			`MISC_REG_GENIO_OE:  misc_rdata_o = {2'h0, genio_oe_o};
			`MISC_REG_GPEXT_IN:  misc_rdata_o = {8'h0, pmod_in_i, 16'h0};
			`MISC_REG_GPEXT_OUT: misc_rdata_o = {1'b0, irda_sd_o, 6'h0, pmod_out_o, 16'h0};
			`MISC_REG_GPEXT_OE:  misc_rdata_o = {8'h0, pmod_oe_o, 16'h0};
			default:             misc_rdata_o = '0;
		endcase
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	// the master drops valid after each access, so the sequencer
	// never sees back-to-back strobes
	a_fsel_strobe_pulse: assert property (
		@(posedge clk48m) disable iff (rst)
		fsel_strobe_o |=> !fsel_strobe_o
	) else $error("flash select strobe held for two cycles");

endmodule

/* source/bus_decoder.sv */
// System bus region decoder
// turns the top address nibble into target selects, muxes the read data,
// merges the ready lines and flags accesses to unmapped regions

`timescale 1ns/1ps
`include "soc_consts.svh"

module bus_decoder import soc_pkg::*; (
	input  logic      clk48m,
	input  logic      rst,
	input  logic      bus_valid_i,
	input  bus_addr_t bus_addr_i,
	input  bus_data_t misc_rdata_i,
	input  bus_data_t ram_rdata_i,
	input  logic      ram_ready_i,
	output logic      misc_sel_o,
	output logic      ram_sel_o,
	output bus_data_t bus_rdata_o,
	output logic      bus_ready_o,
	output logic      bus_error_o
);

	logic [3:0] region;
	logic       hit_misc;
	logic       hit_ram;

	assign region   = bus_addr_i[31:28];
	assign hit_misc = (region == `SOC_REGION_MISC);
	assign hit_ram  = (region == `SOC_REGION_RAM);

	// selects follow valid directly
	assign misc_sel_o  = bus_valid_i && hit_misc;
	assign ram_sel_o   = bus_valid_i && hit_ram;
	assign bus_error_o = bus_valid_i && !hit_misc && !hit_ram;

	always_comb begin
		if (hit_misc) begin
			bus_rdata_o = misc_rdata_i;
		end else if (hit_ram) begin
			bus_rdata_o = ram_rdata_i;
		end else begin
			bus_rdata_o = `SOC_BUS_ERROR_DATA;
		end
	end

	// misc registers and bus errors complete with no wait state,
	// the scratch memory brings its own ready
	assign bus_ready_o = misc_sel_o || ram_ready_i || bus_error_o;

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	// the memory must only answer while it is addressed
	a_ram_ready_selected: assert property (
		@(posedge clk48m) disable iff (rst)
		ram_ready_i |-> ram_sel_o
	) else $error("scratch memory ready without select");

endmodule

/* source/soc_pkg.sv */
// SoC bus types
// vector widths shared by the decoder, register block, memory and sequencer

package soc_pkg;

	// bus side
	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	// zero strobes mean a read
	typedef logic [3:0]  bus_strb_t;

	// misc register index from address bits 6:2
	typedef logic [4:0]  misc_idx_t;

	// io banks
	typedef logic [29:0] genio_t;
	typedef logic [7:0]  pmod_t;
	typedef logic [15:0] led_t;

	// flash select sequencer states
	typedef enum logic [1:0] {
		FSEL_IDLE,
		FSEL_COUNT,
		FSEL_RELOAD
	} fsel_state_t;

endpackage

/* source/soc_consts.svh */
// SoC bus constants
// region codes, misc register indices, flash select timing and memory size

`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// ---------------------------------------------------------------------------
// address regions, top nibble of the bus address
// ---------------------------------------------------------------------------
`define SOC_REGION_MISC       4'h2
`define SOC_REGION_RAM        4'h4

// read value returned for an unmapped region
`define SOC_BUS_ERROR_DATA    32'hDEADBEEF
`define SOC_VERSION           32'h00000000

// ---------------------------------------------------------------------------
// misc register indices, address bits 6:2
// ---------------------------------------------------------------------------
`define MISC_REG_LED          5'd0
`define MISC_REG_BTN          5'd1
`define MISC_REG_SOC_VER      5'd2
`define MISC_REG_FLASH_SEL    5'd13
`define MISC_REG_GENIO_IN     5'd17
`define MISC_REG_GENIO_OUT    5'd18
`define MISC_REG_GENIO_OE     5'd19
`define MISC_REG_GENIO_W2S    5'd20
`define MISC_REG_GENIO_W2C    5'd21
`define MISC_REG_GPEXT_IN     5'd22
`define MISC_REG_GPEXT_OUT    5'd23
`define MISC_REG_GPEXT_OE     5'd24
`define MISC_REG_GPEXT_W2S    5'd25
`define MISC_REG_GPEXT_W2C    5'd26

// ---------------------------------------------------------------------------
// flash select sequencer
// ---------------------------------------------------------------------------
// matched against bits 31:8 of the FLASH_SEL write
`define FSEL_RELOAD_KEY       24'hD0F1A5
`define FSEL_DELAY_START      3'd7
// select clock is high while the counter is inside this window
`define FSEL_CLK_HI           3'd5
`define FSEL_CLK_LO           3'd3

// scratch memory depth in words
`define RAM_WORDS             64

`endif
